// ==== Bender.yml ====
package:
  name: conv_window

sources:
  # packages first, then the design
  - files:
      - rtl/conv_geom_pkg.sv
      - rtl/conv_ctrl_pkg.sv
      - rtl/op_planner.sv
      - rtl/fill_aligner.sv
      - rtl/row_shift_bank.sv
      - rtl/conv_window.sv
  - target: test
    files:
      - dv/conv_window_tb.sv

// ==== conv_window.f ====
rtl/conv_geom_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/op_planner.sv
rtl/fill_aligner.sv
rtl/row_shift_bank.sv
rtl/conv_window.sv
dv/conv_window_tb.sv

// ==== dv/conv_window_tb.sv ====
`timescale 1ns/10ps

module conv_window_tb;

    localparam int reg_num       = conv_geom_pkg::default_reg_num;
    localparam int pixels_in_row = conv_geom_pkg::default_pixels_in_row;
    localparam int pw            = conv_geom_pkg::pix_bits;
    localparam int sw            = conv_geom_pkg::small_bits;
    localparam int iw            = conv_geom_pkg::idx_bits;
    localparam int row_w         = pixels_in_row * pw;
    localparam int num_tiles     = 300;
    localparam int reset_cycles  = 16;
    localparam int max_shift     = 9;
    localparam real period_ns    = 40.0;
    localparam real watchdog_ns  =
        (num_tiles * (max_shift + 6) + reset_cycles + 50) * period_ns;

    logic             clk;
    logic             reset;
    logic             req;
    logic             ack;
    logic [sw-1:0]    slab_num;
    logic [sw-1:0]    east_pad;
    logic [sw-1:0]    shift_count;
    logic [sw-1:0]    s;
    logic [iw-1:0]    reg_start_idx;
    logic [iw-1:0]    reg_end_idx;
    logic [row_w-1:0] row1_pixels;
    logic [row_w-1:0] row2_pixels;
    logic [row_w-1:0] row3_pixels;
    logic [2*pw-1:0]  row1_slab;
    logic [2*pw-1:0]  row2_slab;
    logic [2*pw-1:0]  row3_slab;
    logic [row_w-1:0] re_row1_pixels;
    logic [row_w-1:0] re_row2_pixels;
    logic [row_w-1:0] re_row3_pixels;

    integer        seed = 5;
    int            mismatch_count;
    int            protocol_count;
    logic [pw-1:0] mdl [3][reg_num];        // reference register image
    logic [pw-1:0] px  [3][pixels_in_row];
    logic [pw-1:0] sl  [3][2];
    int            t_start;
    int            t_end;
    int            t_slab;
    int            t_pad;
    int            t_shift;
    int            t_s;

    conv_window DUT (
        .clk(clk), .reset(reset), .req(req), .ack(ack),
        .slab_num(slab_num), .east_pad(east_pad), .shift_count(shift_count), .s(s),
        .reg_start_idx(reg_start_idx), .reg_end_idx(reg_end_idx),
        .row1_pixels(row1_pixels), .row2_pixels(row2_pixels), .row3_pixels(row3_pixels),
        .row1_slab(row1_slab), .row2_slab(row2_slab), .row3_slab(row3_slab),
        .re_row1_pixels(re_row1_pixels), .re_row2_pixels(re_row2_pixels),
        .re_row3_pixels(re_row3_pixels)
    );

    always #(period_ns / 2) clk = ~clk;

    function automatic int rand_between(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [row_w-1:0] actual_row(int r);
        case (r)
            0:       return re_row1_pixels;
            1:       return re_row2_pixels;
            default: return re_row3_pixels;
        endcase
    endfunction

    // stride rule applied to the model image
    function automatic logic [row_w-1:0] expected_row(int r);
        logic [row_w-1:0] v;
        v = '0;
        for (int j = 0; j < pixels_in_row; j++) begin
            if (t_s == 1 && j < reg_num) begin
                v[j*pw +: pw] = mdl[r][j];
            end else if (t_s == 2 && 2 * j < reg_num) begin
                v[j*pw +: pw] = mdl[r][2*j];
            end
        end
        return v;
    endfunction

    function automatic logic [row_w-1:0] pack_row(int r);
        logic [row_w-1:0] v;
        for (int k = 0; k < pixels_in_row; k++) begin
            v[k*pw +: pw] = px[r][k];
        end
        return v;
    endfunction

    task automatic check_rows(input string name, input int tile);
        for (int r = 0; r < 3; r++) begin
            if (actual_row(r) !== expected_row(r)) begin
                mismatch_count++;
                $display("MISMATCH %s tile %0d row%0d expected %h actual %h",
                         name, tile, r + 1, expected_row(r), actual_row(r));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_load();
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < reg_num && p < t_end + t_pad; p++) begin
                if (p >= t_start - 1 && p < t_end) begin
                    mdl[r][p] = px[r][p - (t_start - 1)];
                end else if (p == 0 && t_slab >= 1) begin
                    mdl[r][p] = sl[r][0];
                end else if (p == 1 && t_slab == 2) begin
                    mdl[r][p] = sl[r][1];
                end else begin
                    mdl[r][p] = '0;  // west gap and east pad
                end
            end
        end
    endtask

    task automatic model_shift();
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < reg_num - 1; p++) begin
                mdl[r][p] = mdl[r][p+1];
            end
        end
    endtask

    task automatic draw_tile();
        int sel;
        t_start = rand_between(3, 20);
        t_end   = t_start - 1 + rand_between(1, 32);
        t_slab  = rand_between(0, 2);
        t_pad   = rand_between(0, 5);
        t_shift = rand_between(0, max_shift);
        sel     = rand_between(0, 9);
        t_s     = (sel == 0) ? 3 : (sel < 5) ? 1 : 2;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < pixels_in_row; k++) begin
                px[r][k] = pw'($random(seed));
            end
            sl[r][0] = pw'($random(seed));
            sl[r][1] = pw'($random(seed));
        end
    endtask

    // called on a rising edge
    task automatic drive_tile();
        req           <= 1'b1;
        reg_start_idx <= iw'(t_start);
        reg_end_idx   <= iw'(t_end);
        slab_num      <= sw'(t_slab);
        east_pad      <= sw'(t_pad);
        shift_count   <= sw'(t_shift);
        s             <= sw'(t_s);
        row1_pixels   <= pack_row(0);
        row2_pixels   <= pack_row(1);
        row3_pixels   <= pack_row(2);
        row1_slab     <= {sl[0][1], sl[0][0]};
        row2_slab     <= {sl[1][1], sl[1][0]};
        row3_slab     <= {sl[2][1], sl[2][0]};
    endtask

    task automatic run_tile(input int n);
        string            name;
        int               lat;
        int               extra;
        draw_tile();
        @(posedge clk);
        drive_tile();
        model_load();
        repeat (t_shift) model_shift();

        // edges counted from the drive edge
        @(negedge clk);
        lat = 0;
        while (!ack && lat <= max_shift + 4) begin
            @(negedge clk);
            lat++;
        end
        if (!ack) begin
            protocol_count++;
            $display("tile %0d: ack never rose after req was raised", n);
        end else if (lat != t_shift + 2) begin
            mismatch_count++;
            $display("MISMATCH ack_latency tile %0d expected %0d actual %0d",
                     n, t_shift + 2, lat);
        end

        if (t_s == 3 || t_s == 2)         name = "stride_select";
        else if (t_shift == 0)            name = "load_window";
        else                              name = "shift_result";
        check_rows(name, n);

        // host keeps req high for a while in done
        extra = rand_between(0, 5);
        repeat (extra) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                mismatch_count++;
                $display("MISMATCH backpressure_hold tile %0d expected 1 actual %b", n, ack);
            end
            check_rows("backpressure_hold", n);
        end

        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        lat = 0;
        while (ack && lat <= 4) begin
            @(negedge clk);
            lat++;
        end
        if (ack) begin
            protocol_count++;
            $display("tile %0d: ack stayed high after req was dropped", n);
        end else if (lat != 1) begin
            mismatch_count++;
            $display("MISMATCH ack_latency tile %0d expected 1 actual %0d", n, lat);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        req           = 1'b0;
        slab_num      = '0;
        east_pad      = '0;
        shift_count   = '0;
        s             = sw'(1);
        reg_start_idx = '0;
        reg_end_idx   = '0;
        row1_pixels   = '0;
        row2_pixels   = '0;
        row3_pixels   = '0;
        row1_slab     = '0;
        row2_slab     = '0;
        row3_slab     = '0;
        mismatch_count = 0;
        protocol_count = 0;
        t_s            = 1;
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < reg_num; p++) mdl[r][p] = '0;
        end

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            mismatch_count++;
            $display("MISMATCH reset_state expected 0 actual %b", ack);
        end
        check_rows("reset_state", 0);

        for (int n = 0; n < num_tiles; n++) begin
            run_tile(n);
        end

        $display("errors: %0d mismatches, %0d protocol failures",
                 mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0t", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== rtl/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    localparam int op_bits = 2;

    // per-register operation
    typedef enum logic [op_bits-1:0] {
        op_hold  = 2'd0,
        op_fill  = 2'd1,  // take aligner byte
        op_shift = 2'd2   // take upper neighbor
    } reg_op_e;

    // sequencer phases
    typedef enum logic [1:0] {
        ph_idle  = 2'd0,
        ph_load  = 2'd1,
        ph_shift = 2'd2,
        ph_done  = 2'd3
    } phase_e;

endpackage

// ==== rtl/conv_geom_pkg.sv ====
package conv_geom_pkg;

    // pixel and index widths
    localparam int pix_bits   = 8;
    localparam int idx_bits   = 16;
    localparam int small_bits = 4;  // slab_num, east_pad, s, shift_count

    ////////////////////////////////////////////////////////////////////////////
    // default geometry, overridable from the top level
    ////////////////////////////////////////////////////////////////////////////

    localparam int default_reg_num       = 70;
    localparam int default_pixels_in_row = 32;

endpackage

// ==== rtl/conv_window.sv ====
`timescale 1ns/10ps

module conv_window #(
    parameter int reg_num       = conv_geom_pkg::default_reg_num,
    parameter int pixels_in_row = conv_geom_pkg::default_pixels_in_row
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              req,
    output logic                                              ack,
    input  logic [conv_geom_pkg::small_bits-1:0]              slab_num,
    input  logic [conv_geom_pkg::small_bits-1:0]              east_pad,
    input  logic [conv_geom_pkg::small_bits-1:0]              shift_count,
    input  logic [conv_geom_pkg::small_bits-1:0]              s,
    input  logic [conv_geom_pkg::idx_bits-1:0]                reg_start_idx,
    input  logic [conv_geom_pkg::idx_bits-1:0]                reg_end_idx,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row1_pixels,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row2_pixels,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row3_pixels,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row1_slab,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row2_slab,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row3_slab,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row1_pixels,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row2_pixels,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row3_pixels
);

    logic [reg_num*conv_ctrl_pkg::op_bits-1:0]  ops;
    logic [reg_num*conv_geom_pkg::pix_bits-1:0] row1_fill;
    logic [reg_num*conv_geom_pkg::pix_bits-1:0] row2_fill;
    logic [reg_num*conv_geom_pkg::pix_bits-1:0] row3_fill;

    op_planner #(
        .reg_num(reg_num)
    ) u_op_planner (
        .clk(clk),
        .reset(reset),
        .req(req),
        .east_pad(east_pad),
        .shift_count(shift_count),
        .reg_end_idx(reg_end_idx),
        .ack(ack),
        .ops(ops)
    );

    fill_aligner #(
        .reg_num(reg_num),
        .pixels_in_row(pixels_in_row)
    ) u_fill_aligner (
        .slab_num(slab_num),
        .reg_start_idx(reg_start_idx),
        .reg_end_idx(reg_end_idx),
        .row1_pixels(row1_pixels),
        .row2_pixels(row2_pixels),
        .row3_pixels(row3_pixels),
        .row1_slab(row1_slab),
        .row2_slab(row2_slab),
        .row3_slab(row3_slab),
        .row1_fill(row1_fill),
        .row2_fill(row2_fill),
        .row3_fill(row3_fill)
    );

    row_shift_bank #(
        .reg_num(reg_num),
        .pixels_in_row(pixels_in_row)
    ) u_row_shift_bank (
        .clk(clk),
        .reset(reset),
        .s(s),
        .ops(ops),
        .row1_fill(row1_fill),
        .row2_fill(row2_fill),
        .row3_fill(row3_fill),
        .re_row1_pixels(re_row1_pixels),
        .re_row2_pixels(re_row2_pixels),
        .re_row3_pixels(re_row3_pixels)
    );

endmodule

// ==== rtl/fill_aligner.sv ====
`timescale 1ns/10ps

module fill_aligner #(
    parameter int reg_num       = 70,
    parameter int pixels_in_row = 32
) (
    input  logic [conv_geom_pkg::small_bits-1:0]              slab_num,
    input  logic [conv_geom_pkg::idx_bits-1:0]                reg_start_idx,
    input  logic [conv_geom_pkg::idx_bits-1:0]                reg_end_idx,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row1_pixels,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row2_pixels,
    input  logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  row3_pixels,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row1_slab,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row2_slab,
    input  logic [2*conv_geom_pkg::pix_bits-1:0]              row3_slab,
    output logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row1_fill,
    output logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row2_fill,
    output logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row3_fill
);

    localparam int fill_w = reg_num * conv_geom_pkg::pix_bits;
    localparam int slab_w = 2 * conv_geom_pkg::pix_bits;

    logic [31:0]       lo_shift;   // bit offset of first placed pixel
    logic [31:0]       hi_gap;     // registers above reg_end_idx
    logic [fill_w-1:0] keep_mask;
    logic [slab_w-1:0] slab_keep;

    ////////////////////////////////////////////////////////////////////////////
    // geometry shared by all three rows
    ////////////////////////////////////////////////////////////////////////////

    assign lo_shift  = (reg_start_idx - 1'b1) * conv_geom_pkg::pix_bits;
    assign hi_gap    = reg_num - reg_end_idx;
    assign keep_mask = {fill_w{1'b1}} >> (hi_gap * conv_geom_pkg::pix_bits);

    // slab bytes land in registers 0 and 1
    always_comb begin
        case (slab_num)
            4'd2:    slab_keep = {slab_w{1'b1}};
            4'd1:    slab_keep = {{conv_geom_pkg::pix_bits{1'b0}},
                                  {conv_geom_pkg::pix_bits{1'b1}}};
            default: slab_keep = '0;
        endcase
    end

    // positions outside both ranges stay zero, west pad gap
    assign row1_fill = ((fill_w'(row1_pixels) << lo_shift) & keep_mask)
                     | fill_w'(row1_slab & slab_keep);
    assign row2_fill = ((fill_w'(row2_pixels) << lo_shift) & keep_mask)
                     | fill_w'(row2_slab & slab_keep);
    assign row3_fill = ((fill_w'(row3_pixels) << lo_shift) & keep_mask)
                     | fill_w'(row3_slab & slab_keep);

endmodule

// ==== rtl/op_planner.sv ====
`timescale 1ns/10ps

module op_planner #(
    parameter int reg_num = 70
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      req,
    input  logic [conv_geom_pkg::small_bits-1:0]      east_pad,
    input  logic [conv_geom_pkg::small_bits-1:0]      shift_count,
    input  logic [conv_geom_pkg::idx_bits-1:0]        reg_end_idx,
    output logic                                      ack,
    output logic [reg_num*conv_ctrl_pkg::op_bits-1:0] ops
);

    conv_ctrl_pkg::phase_e phase;

    logic [conv_geom_pkg::small_bits-1:0] shift_cnt;  // shifts done so far
    logic                                 shift_last;
    logic [conv_geom_pkg::idx_bits:0]     fill_limit;

    // east pad window, registers above it keep old contents
    assign fill_limit = reg_end_idx + east_pad;

    assign shift_last = (shift_cnt + 1'b1) == shift_count;

    ////////////////////////////////////////////////////////////////////////////
    // phase sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= conv_ctrl_pkg::ph_idle;
            shift_cnt <= '0;
        end else begin
            case (phase)
                conv_ctrl_pkg::ph_idle: begin
                    if (req) begin
                        phase <= conv_ctrl_pkg::ph_load;
                    end
                end
                conv_ctrl_pkg::ph_load: begin
                    shift_cnt <= '0;
                    if (shift_count == '0) begin
                        phase <= conv_ctrl_pkg::ph_done;  // nothing to shift
                    end else begin
                        phase <= conv_ctrl_pkg::ph_shift;
                    end
                end
                conv_ctrl_pkg::ph_shift: begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_last) begin
                        phase <= conv_ctrl_pkg::ph_done;
                    end
                end
                default: begin
                    // window held until host drops req
                    if (!req) begin
                        phase <= conv_ctrl_pkg::ph_idle;
                    end
                end
            endcase
        end
    end

    assign ack = (phase == conv_ctrl_pkg::ph_done);

    ////////////////////////////////////////////////////////////////////////////
    // per register op codes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < reg_num; p++) begin
            case (phase)
                conv_ctrl_pkg::ph_load: begin
                    if (p < fill_limit) begin
                        ops[p*conv_ctrl_pkg::op_bits +: conv_ctrl_pkg::op_bits] =
                            conv_ctrl_pkg::op_fill;
                    end else begin
                        ops[p*conv_ctrl_pkg::op_bits +: conv_ctrl_pkg::op_bits] =
                            conv_ctrl_pkg::op_hold;
                    end
                end
                conv_ctrl_pkg::ph_shift: begin
                    if (p < reg_num - 1) begin
                        ops[p*conv_ctrl_pkg::op_bits +: conv_ctrl_pkg::op_bits] =
                            conv_ctrl_pkg::op_shift;
                    end else begin
                        // top register has no upper neighbor
                        ops[p*conv_ctrl_pkg::op_bits +: conv_ctrl_pkg::op_bits] =
                            conv_ctrl_pkg::op_hold;
                    end
                end
                default: begin
                    ops[p*conv_ctrl_pkg::op_bits +: conv_ctrl_pkg::op_bits] =
                        conv_ctrl_pkg::op_hold;
                end
            endcase
        end
    end

endmodule

// ==== rtl/row_shift_bank.sv ====
`timescale 1ns/10ps

module row_shift_bank #(
    parameter int reg_num       = 70,
    parameter int pixels_in_row = 32
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [conv_geom_pkg::small_bits-1:0]              s,
    input  logic [reg_num*conv_ctrl_pkg::op_bits-1:0]         ops,
    input  logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row1_fill,
    input  logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row2_fill,
    input  logic [reg_num*conv_geom_pkg::pix_bits-1:0]        row3_fill,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row1_pixels,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row2_pixels,
    output logic [pixels_in_row*conv_geom_pkg::pix_bits-1:0]  re_row3_pixels
);

    localparam int pw = conv_geom_pkg::pix_bits;
    localparam int ow = conv_ctrl_pkg::op_bits;

    logic [reg_num*pw-1:0]       fill_img [3];
    logic [pixels_in_row*pw-1:0] out_img  [3];
    logic [pw-1:0]               bank     [3][reg_num];
    logic [pw-1:0]               upper    [3][reg_num];  // shift source per byte

    assign fill_img[0] = row1_fill;
    assign fill_img[1] = row2_fill;
    assign fill_img[2] = row3_fill;

    for (genvar r = 0; r < 3; r++) begin : g_row

        ////////////////////////////////////////////////////////////////////////
        // byte registers
        ////////////////////////////////////////////////////////////////////////

        for (genvar p = 0; p < reg_num; p++) begin : g_up
            if (p < reg_num - 1) begin : g_mid
                assign upper[r][p] = bank[r][p+1];
            end else begin : g_top
                assign upper[r][p] = bank[r][p];  // shift acts as hold
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                for (int p = 0; p < reg_num; p++) begin
                    bank[r][p] <= '0;
                end
            end else begin
                for (int p = 0; p < reg_num; p++) begin
                    case (ops[p*ow +: ow])
                        conv_ctrl_pkg::op_fill:  bank[r][p] <= fill_img[r][p*pw +: pw];
                        conv_ctrl_pkg::op_shift: bank[r][p] <= upper[r][p];
                        default:                 bank[r][p] <= bank[r][p];
                    endcase
                end
            end
        end

        // stride select, zero past the last register
        for (genvar j = 0; j < pixels_in_row; j++) begin : g_out
            logic [pw-1:0] s1_pix;
            logic [pw-1:0] s2_pix;

            assign s1_pix = (j < reg_num) ? bank[r][j % reg_num] : '0;
            assign s2_pix = (2 * j < reg_num) ? bank[r][(2 * j) % reg_num] : '0;

            assign out_img[r][j*pw +: pw] = (s == 4'd1) ? s1_pix :
                                            (s == 4'd2) ? s2_pix : '0;
        end
    end

    assign re_row1_pixels = out_img[0];
    assign re_row2_pixels = out_img[1];
    assign re_row3_pixels = out_img[2];

endmodule
